// ==== design/entropy_src_pkg.sv ====
// Shared definitions for the entropy source core
//   - noise bus and repetition counter widths
//   - default repetition-count threshold
//   - command opcode and main state encodings

package entropy_src_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and defaults
  ////////////////////////////////////////////////////////////

  // Noise bus, one health test lane per bit
  parameter int RngBusWidth = 4;

  // Repetition counters and threshold register
  parameter int RepCntWidth = 8;

  // Threshold loaded at reset
  parameter logic [RepCntWidth-1:0] DefaultRepThresh = RepCntWidth'(8);

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Command opcodes, sampled with cmd_valid_i
  typedef enum logic [2:0] {
    CMD_NOP         = 3'd0,
    CMD_ENABLE      = 3'd1,
    CMD_DISABLE     = 3'd2,
    CMD_SET_THRESH  = 3'd3,
    CMD_CLEAR_ALERT = 3'd4
  } es_cmd_e;

  // Main FSM states
  // the unused fourth code falls back to disabled
  typedef enum logic [1:0] {
    MAIN_DISABLED = 2'b00,
    MAIN_RUN      = 2'b01,
    MAIN_ALERT    = 2'b10
  } es_main_state_e;

endpackage

// ==== design/entropy_src_cmd_decode.sv ====
// Command decoder for the entropy source core
//   - main FSM (disabled, run, alert)
//   - repetition-count threshold register
//   - clear pulse on every entry into run

`timescale 1ns/1ps

module entropy_src_cmd_decode
  import entropy_src_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cmd_valid_i,
  input  es_cmd_e                cmd_op_i,
  input  logic [RepCntWidth-1:0] cmd_data_i,
  input  logic                   fail_i,
  output logic                   run_o,
  output logic                   clear_o,
  output logic [RepCntWidth-1:0] rep_thresh_o,
  output logic                   es_enabled_o,
  output logic                   health_test_failed_o
);

  es_main_state_e state_q;
  es_main_state_e state_d;
  logic           cmd_enable;
  logic           cmd_disable;
  logic           cmd_clear_alert;
  logic           cmd_set_thresh;

  assign cmd_enable      = cmd_valid_i && (cmd_op_i == CMD_ENABLE);
  assign cmd_disable     = cmd_valid_i && (cmd_op_i == CMD_DISABLE);
  assign cmd_clear_alert = cmd_valid_i && (cmd_op_i == CMD_CLEAR_ALERT);
  assign cmd_set_thresh  = cmd_valid_i && (cmd_op_i == CMD_SET_THRESH);

  ////////////////////////////////////////////////////////////
  // Main FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MAIN_DISABLED: begin
        if (cmd_enable) begin
          state_d = MAIN_RUN;
        end
      end
      MAIN_RUN: begin
        // Disable wins over a failure in the same cycle
        if (cmd_disable) begin
          state_d = MAIN_DISABLED;
        end else if (fail_i) begin
          state_d = MAIN_ALERT;
        end
      end
      MAIN_ALERT: begin
        if (cmd_disable) begin
          state_d = MAIN_DISABLED;
        end else if (cmd_clear_alert) begin
          state_d = MAIN_RUN;
        end
      end
      default: begin
        state_d = MAIN_DISABLED;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= MAIN_DISABLED;
      clear_o      <= 1'b0;
      rep_thresh_o <= DefaultRepThresh;
    end else begin
      state_q <= state_d;
      clear_o <= (state_d == MAIN_RUN) && (state_q != MAIN_RUN);
      if (cmd_set_thresh) begin
        rep_thresh_o <= cmd_data_i;
      end
    end
  end

  // Status decoded straight from the state register
  assign run_o                = (state_q == MAIN_RUN);
  assign es_enabled_o         = (state_q != MAIN_DISABLED);
  assign health_test_failed_o = (state_q == MAIN_ALERT);

endmodule

// ==== design/entropy_src_repcnt_ht.sv ====
// Repetition-count health test
//   - one counter and previous bit per noise lane
//   - registered forwarding of healthy symbols
//   - fail pulse instead of the symbol when a lane hits the threshold

`timescale 1ns/1ps

module entropy_src_repcnt_ht
  import entropy_src_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   run_i,
  input  logic                   clear_i,
  input  logic [RepCntWidth-1:0] rep_thresh_i,
  input  logic                   rng_valid_i,
  input  logic [RngBusWidth-1:0] rng_data_i,
  output logic                   fail_o,
  output logic                   sym_valid_o,
  output logic [RngBusWidth-1:0] sym_o
);

  logic                   accept;
  logic                   first_q;
  logic                   first;
  logic                   pend_q;
  logic [RngBusWidth-1:0] prev_bit_q;
  logic [RngBusWidth-1:0] lane_hit;
  logic                   any_hit;

  // Noise is only taken while running
  assign accept = run_i && rng_valid_i;

  // Counters restart on the first symbol after a clear
  assign first = first_q || clear_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      first_q <= 1'b1;
      pend_q  <= 1'b0;
    end else begin
      pend_q <= accept;
      if (accept) begin
        first_q <= 1'b0;
      end else if (clear_i) begin
        first_q <= 1'b1;
      end
    end
  end

  // Last accepted symbol, also the one waiting to be forwarded
  always_ff @(posedge clk_i) begin
    if (accept) begin
      prev_bit_q <= rng_data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Per-lane repetition counters
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < RngBusWidth; i++) begin : gen_lanes
    logic [RepCntWidth-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q <= '0;
      end else if (accept) begin
        if (first || (rng_data_i[i] != prev_bit_q[i])) begin
          cnt_q <= RepCntWidth'(1);
        end else if (cnt_q != '1) begin
          // Saturate on long runs
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end

    assign lane_hit[i] = (cnt_q >= rep_thresh_i);
  end

  assign any_hit = |lane_hit;

  // Second stage forwards the symbol or pulses fail one cycle after the counters
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fail_o      <= 1'b0;
      sym_valid_o <= 1'b0;
    end else begin
      fail_o      <= pend_q && run_i && any_hit;
      sym_valid_o <= pend_q && run_i && !any_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pend_q) begin
      sym_o <= prev_bit_q;
    end
  end

endmodule

// ==== design/entropy_src_packer.sv ====
// Entropy word packer
//   - shifts healthy symbols in, first symbol ends in the low nibble
//   - one-cycle strobe when a full word is collected

`timescale 1ns/1ps

module entropy_src_packer
  import entropy_src_pkg::*;
#(
  parameter int EntropyWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    clear_i,
  input  logic                    sym_valid_i,
  input  logic [RngBusWidth-1:0]  sym_i,
  output logic                    entropy_valid_o,
  output logic [EntropyWidth-1:0] entropy_o
);

  localparam int NumSyms     = EntropyWidth / RngBusWidth;
  localparam int SymCntWidth = (NumSyms > 1) ? $clog2(NumSyms) : 1;

  logic [SymCntWidth-1:0]  sym_cnt_q;
  logic                    last_sym;
  logic [EntropyWidth-1:0] word_q;

  assign last_sym = (sym_cnt_q == SymCntWidth'(NumSyms - 1));

  // Symbol count and word strobe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sym_cnt_q       <= '0;
      entropy_valid_o <= 1'b0;
    end else begin
      entropy_valid_o <= 1'b0;
      if (clear_i) begin
        sym_cnt_q <= '0;
      end else if (sym_valid_i) begin
        if (last_sym) begin
          sym_cnt_q       <= '0;
          entropy_valid_o <= 1'b1;
        end else begin
          sym_cnt_q <= sym_cnt_q + 1'b1;
        end
      end
    end
  end

  // New symbols enter at the top and move down
  always_ff @(posedge clk_i) begin
    if (sym_valid_i && !clear_i) begin
      word_q <= (word_q >> RngBusWidth) |
                (EntropyWidth'(sym_i) << (EntropyWidth - RngBusWidth));
    end
  end

  // Word is complete and stable while the strobe is high
  assign entropy_o = word_q;

endmodule

// ==== design/entropy_src.sv ====
// Entropy source core top level
//   - command decoder and main FSM
//   - repetition-count health test
//   - entropy word packer

`timescale 1ns/1ps

module entropy_src
  import entropy_src_pkg::*;
#(
  parameter int EntropyWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_valid_i,
  input  es_cmd_e                 cmd_op_i,
  input  logic [RepCntWidth-1:0]  cmd_data_i,
  input  logic                    rng_valid_i,
  input  logic [RngBusWidth-1:0]  rng_data_i,
  output logic                    entropy_valid_o,
  output logic [EntropyWidth-1:0] entropy_o,
  output logic                    es_enabled_o,
  output logic                    health_test_failed_o
);

  logic                   run;
  logic                   clear;
  logic                   fail;
  logic [RepCntWidth-1:0] rep_thresh;
  logic                   sym_valid;
  logic [RngBusWidth-1:0] sym;

  entropy_src_cmd_decode u_cmd_decode (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .cmd_valid_i         (cmd_valid_i),
    .cmd_op_i            (cmd_op_i),
    .cmd_data_i          (cmd_data_i),
    .fail_i              (fail),
    .run_o               (run),
    .clear_o             (clear),
    .rep_thresh_o        (rep_thresh),
    .es_enabled_o        (es_enabled_o),
    .health_test_failed_o(health_test_failed_o)
  );

  entropy_src_repcnt_ht u_repcnt_ht (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .run_i       (run),
    .clear_i     (clear),
    .rep_thresh_i(rep_thresh),
    .rng_valid_i (rng_valid_i),
    .rng_data_i  (rng_data_i),
    .fail_o      (fail),
    .sym_valid_o (sym_valid),
    .sym_o       (sym)
  );

  entropy_src_packer #(
    .EntropyWidth(EntropyWidth)
  ) u_packer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .clear_i        (clear),
    .sym_valid_i    (sym_valid),
    .sym_i          (sym),
    .entropy_valid_o(entropy_valid_o),
    .entropy_o      (entropy_o)
  );

endmodule

// ==== sim/entropy_src_properties.sv ====
// Concurrent checks on the entropy source ports
//   - no word strobe during an alert
//   - enable command response
//   - quiet strobes and status in reset

`timescale 1ns/1ps

module entropy_src_properties
  import entropy_src_pkg::*;
(
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    cmd_valid_i,
  input es_cmd_e cmd_op_i,
  input logic    entropy_valid_o,
  input logic    es_enabled_o,
  input logic    health_test_failed_o
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  a_no_word_in_alert: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(entropy_valid_o && health_test_failed_o)
  ) else begin
    fail_cnt++;
    $error("entropy word strobed during an alert");
  end

  a_enable_response: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (cmd_valid_i && (cmd_op_i == CMD_ENABLE) && !es_enabled_o) |=> es_enabled_o
  ) else begin
    fail_cnt++;
    $error("enable command did not raise es_enabled_o");
  end

  a_reset_quiet: assert property (
    @(posedge clk_i)
    !rst_n_i |-> (!entropy_valid_o && !es_enabled_o && !health_test_failed_o)
  ) else begin
    fail_cnt++;
    $error("outputs active during reset");
  end

endmodule

// ==== sim/entropy_src_tb.sv ====
// Testbench for the entropy source core
//   - clock, reset and strobe stimulus with LCG symbols and gaps
//   - reference model of the counters, threshold, FSM and partial word
//   - word compare process, status checks and watchdog

`timescale 1ns/1ps

module entropy_src_tb
  import entropy_src_pkg::*;
();

  localparam int ClkPeriod      = 100;
  localparam int EntropyWidth   = 32;
  localparam int NumSyms        = EntropyWidth / RngBusWidth;
  localparam int NumTests       = 8;
  localparam int MaxGap         = 7;
  localparam int WatchdogCycles = (NumTests + 8) * 8 * (MaxGap + 4);

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  logic                    cmd_valid_i;
  es_cmd_e                 cmd_op_i;
  logic [RepCntWidth-1:0]  cmd_data_i;
  logic                    rng_valid_i;
  logic [RngBusWidth-1:0]  rng_data_i;
  logic                    entropy_valid_o;
  logic [EntropyWidth-1:0] entropy_o;
  logic                    es_enabled_o;
  logic                    health_test_failed_o;

  // Model state
  es_main_state_e          m_state;
  logic [RepCntWidth-1:0]  m_thresh;
  logic [RepCntWidth-1:0]  m_cnt [RngBusWidth];
  logic [RngBusWidth-1:0]  m_prev;
  logic                    m_first;
  int                      m_nsyms;
  logic [EntropyWidth-1:0] m_word;

  logic [EntropyWidth-1:0] exp_q [$];
  logic [EntropyWidth-1:0] exp_word;
  logic [31:0]             seed = 32'hfe96;
  int                      value_errs = 0;
  int                      other_errs = 0;

  entropy_src #(.EntropyWidth(EntropyWidth)) u_entropy_src (.*);

  bind entropy_src entropy_src_properties u_properties (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .cmd_valid_i         (cmd_valid_i),
    .cmd_op_i            (cmd_op_i),
    .entropy_valid_o     (entropy_valid_o),
    .es_enabled_o        (es_enabled_o),
    .health_test_failed_o(health_test_failed_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Reference model for one noise symbol
  // returns 1 on a finished word, 2 on a health test failure
  function automatic int model_sym(input logic [RngBusWidth-1:0] sym,
                                   output logic [EntropyWidth-1:0] word);
    logic hit;
    word = '0;
    hit  = 1'b0;
    if (m_state != MAIN_RUN) begin
      return 0;
    end
    for (int i = 0; i < RngBusWidth; i++) begin
      if (m_first || (sym[i] != m_prev[i])) begin
        m_cnt[i] = RepCntWidth'(1);
      end else if (m_cnt[i] != '1) begin
        m_cnt[i] = m_cnt[i] + 1'b1;
      end
      if (m_cnt[i] >= m_thresh) begin
        hit = 1'b1;
      end
    end
    m_prev  = sym;
    m_first = 1'b0;
    if (hit) begin
      m_state = MAIN_ALERT;
      return 2;
    end
    m_word[RngBusWidth*m_nsyms +: RngBusWidth] = sym;
    m_nsyms++;
    if (m_nsyms == NumSyms) begin
      word    = m_word;
      m_nsyms = 0;
      return 1;
    end
    return 0;
  endfunction

  function automatic void model_cmd(input es_cmd_e op, input logic [RepCntWidth-1:0] data);
    case (op)
      CMD_ENABLE: begin
        if (m_state == MAIN_DISABLED) begin
          m_state = MAIN_RUN;
          m_first = 1'b1;
          m_nsyms = 0;
        end
      end
      CMD_CLEAR_ALERT: begin
        if (m_state == MAIN_ALERT) begin
          m_state = MAIN_RUN;
          m_first = 1'b1;
          m_nsyms = 0;
        end
      end
      CMD_DISABLE:    m_state = MAIN_DISABLED;
      CMD_SET_THRESH: m_thresh = data;
      default: ;
    endcase
  endfunction

  task automatic check_status();
    @(negedge clk_i);
    assert (es_enabled_o == (m_state != MAIN_DISABLED)) else begin
      value_errs++;
      $display("ERR %0t: es_enabled_o is %b, model state %s", $time, es_enabled_o,
               m_state.name());
    end
    assert (health_test_failed_o == (m_state == MAIN_ALERT)) else begin
      value_errs++;
      $display("ERR %0t: health_test_failed_o is %b, model state %s", $time,
               health_test_failed_o, m_state.name());
    end
  endtask

  task automatic send_cmd(input es_cmd_e op, input logic [RepCntWidth-1:0] data);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_op_i    <= op;
    cmd_data_i  <= data;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    cmd_op_i    <= CMD_NOP;
    model_cmd(op, data);
    repeat (2) @(posedge clk_i);
    check_status();
  endtask

  task automatic send_sym(input logic [RngBusWidth-1:0] sym);
    logic [EntropyWidth-1:0] word;
    logic [31:0]             rnd;
    int                      gap;
    @(posedge clk_i);
    rng_valid_i <= 1'b1;
    rng_data_i  <= sym;
    @(posedge clk_i);
    rng_valid_i <= 1'b0;
    if (model_sym(sym, word) == 1) begin
      exp_q.push_back(word);
    end
    rnd = next_rand();
    gap = 4 + int'(rnd[17:16]);
    repeat (gap) @(posedge clk_i);
    check_status();
  endtask

  // Random symbols with any alert cleared as soon as the model sees it
  task automatic run_syms(input int count);
    logic [31:0] rnd;
    for (int n = 0; n < count; n++) begin
      rnd = next_rand();
      send_sym(rnd[23:20]);
      if (m_state == MAIN_ALERT) begin
        send_cmd(CMD_CLEAR_ALERT, '0);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Word compare
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (entropy_valid_o === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        other_errs++;
        $display("Entropy word %h appeared at %0t with no word predicted", entropy_o, $time);
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        assert (entropy_o == exp_word) else begin
          value_errs++;
          $display("ERR %0t: entropy word %h, expected %h", $time, entropy_o, exp_word);
        end
      end
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired before the test sequence finished");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    rst_n_i     <= 1'b0;
    cmd_valid_i <= 1'b0;
    cmd_op_i    <= CMD_NOP;
    cmd_data_i  <= '0;
    rng_valid_i <= 1'b0;
    rng_data_i  <= '0;
    m_state  = MAIN_DISABLED;
    m_thresh = DefaultRepThresh;
    m_first  = 1'b1;
    m_nsyms  = 0;
    m_prev   = '0;
    m_word   = '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Quiet after reset and noise ignored while disabled
    check_status();
    run_syms(NumSyms);

    // Random words
    send_cmd(CMD_SET_THRESH, RepCntWidth'(12));
    send_cmd(CMD_ENABLE, '0);
    run_syms(NumTests * NumSyms);

    // Repeated lanes trip the alert at a small threshold
    send_cmd(CMD_SET_THRESH, RepCntWidth'(3));
    repeat (3) send_sym(4'h6);
    assert (health_test_failed_o === 1'b1) else begin
      value_errs++;
      $display("ERR %0t: repeated symbols did not raise health_test_failed_o", $time);
    end
    repeat (NumSyms) begin
      rnd = next_rand();
      send_sym(rnd[27:24]);
    end

    // Resume after clear
    send_cmd(CMD_CLEAR_ALERT, '0);
    // Same symbol again stays under the threshold only with restarted counters
    repeat (2) send_sym(4'h6);
    send_cmd(CMD_SET_THRESH, RepCntWidth'(12));
    run_syms(NumSyms);

    // Disable in mid-word and restart from fresh symbols
    run_syms(3);
    send_cmd(CMD_DISABLE, '0);
    send_cmd(CMD_ENABLE, '0);
    run_syms(NumSyms);

    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
             u_entropy_src.u_properties.fail_cnt);
    if (value_errs == 0 && other_errs == 0 && u_entropy_src.u_properties.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
design/entropy_src_pkg.sv
design/entropy_src_cmd_decode.sv
design/entropy_src_repcnt_ht.sv
design/entropy_src_packer.sv
design/entropy_src.sv
sim/entropy_src_properties.sv
sim/entropy_src_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := entropy_src_tb
RTL_TOP    := entropy_src
FILELIST   := verilog.f
FLAGS      := --timing --assert
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0
BUILD_DIR  := obj_dir
RUN_ARGS   := +verilator+error+limit+100
LOG        := sim.log
PASS_MSG   := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "No pass message found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
